// ==== verilog/i2c_cfg.svh ====
`ifndef I2C_CFG_SVH
`define I2C_CFG_SVH

// clk cycles per quarter of one scl bit
`define I2C_QUARTER_CLKS 4

// retries after a nack before the command fails
`define I2C_MAX_RETRY 7

`define I2C_LEN_W 8 // trans_length / dummy_length width

`endif

// ==== verilog/i2c_pkg.sv ====
`default_nettype none

package i2c_pkg;

    // one bus step handed from decode to execute
    typedef enum logic [1:0] {
        STEP_START,
        STEP_STOP,
        STEP_TX_BYTE,
        STEP_RX_BYTE
    } step_kind_t;

    // address byte or plain data byte, same 8 bits on the wire
    typedef union packed {
        struct packed {
            logic [6:0] slave;
            logic       rd;     // 1 = read
        } addr;
        logic [7:0] data;
    } tx_byte_u;

endpackage

`default_nettype wire

// ==== verilog/i2c_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface i2c_step_if;
    import i2c_pkg::*;

    logic       step_req;
    step_kind_t step_kind;
    tx_byte_u   tx_byte;
    logic       master_ack; // low = ack after a received byte
    logic       step_done;

    modport decode (output step_req, step_kind, tx_byte, master_ack, input step_done);
    modport execute (input step_req, step_kind, tx_byte, master_ack, output step_done);
endinterface

interface i2c_done_if;
    logic       byte_done;
    logic       was_rx;
    logic [7:0] rx_byte;
    logic       ack_bit; // sda level in the ack slot

    modport execute (output byte_done, was_rx, rx_byte, ack_bit);
    modport result (input byte_done, was_rx, rx_byte, ack_bit);
endinterface

`default_nettype wire

// ==== verilog/i2c_cmd_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "i2c_cfg.svh"

module i2c_cmd_decode (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   cmd_valid,
    output logic                  cmd_ready,
    output logic                  cmd_done,
    input  wire  [6:0]            slave_addr,
    input  wire                   read_write,
    input  wire  [`I2C_LEN_W-1:0] trans_length,
    input  wire  [`I2C_LEN_W-1:0] dummy_length,
    output logic                  wr_data_ready,
    input  wire  [7:0]            wr_data,
    input  wire                   retry,
    input  wire                   abort,
    i2c_step_if.decode            step
);
    import i2c_pkg::*;

    localparam logic [3:0] PH_IDLE    = 4'd0;
    localparam logic [3:0] PH_START   = 4'd1;
    localparam logic [3:0] PH_ADDR_W  = 4'd2;
    localparam logic [3:0] PH_WRITE   = 4'd3;
    localparam logic [3:0] PH_REG     = 4'd4;
    localparam logic [3:0] PH_RESTART = 4'd5;
    localparam logic [3:0] PH_ADDR_R  = 4'd6;
    localparam logic [3:0] PH_READ    = 4'd7;
    localparam logic [3:0] PH_STOP    = 4'd8;

    logic [3:0]            phase;
    logic                  again;   // start over once the stop is out
    logic [6:0]            addr_q;
    logic                  rw_q;
    logic [`I2C_LEN_W-1:0] trans_q;
    logic [`I2C_LEN_W-1:0] dummy_q;
    logic [`I2C_LEN_W-1:0] trans_cnt;
    logic [`I2C_LEN_W-1:0] dummy_cnt;
    logic                  issue;

    // one idle cycle between steps so a retry or abort from result lands first
    assign issue         = (phase != PH_IDLE) && !step.step_req && !retry && !abort;
    assign cmd_ready     = (phase == PH_IDLE) && !cmd_done;
    assign wr_data_ready = issue && ((phase == PH_WRITE) || (phase == PH_REG));

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            addr_q  <= slave_addr;
            rw_q    <= read_write;
            trans_q <= trans_length;
            dummy_q <= dummy_length;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            case (phase)
                PH_ADDR_W: begin
                    step.tx_byte.addr.slave <= addr_q;
                    step.tx_byte.addr.rd    <= 1'b0;
                end
                PH_ADDR_R: begin
                    step.tx_byte.addr.slave <= addr_q;
                    step.tx_byte.addr.rd    <= 1'b1;
                end
                PH_WRITE, PH_REG: step.tx_byte.data <= wr_data;
                default:          step.tx_byte.data <= 8'hff;
            endcase
            step.master_ack <= (phase == PH_READ) && (trans_cnt == '0); // nack the last one
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase          <= PH_IDLE;
            again          <= 1'b0;
            trans_cnt      <= '0;
            dummy_cnt      <= '0;
            cmd_done       <= 1'b0;
            step.step_req  <= 1'b0;
            step.step_kind <= STEP_START;
        end else begin
            cmd_done <= 1'b0;
            if (cmd_valid && cmd_ready) begin
                phase     <= PH_START;
                trans_cnt <= trans_length;
                dummy_cnt <= dummy_length;
            end else if (retry || abort) begin
                phase     <= PH_STOP;
                again     <= retry;
                trans_cnt <= trans_q;
                dummy_cnt <= dummy_q;
            end else if (issue) begin
                step.step_req <= 1'b1;
                case (phase)
                    PH_START, PH_RESTART: step.step_kind <= STEP_START;
                    PH_STOP:              step.step_kind <= STEP_STOP;
                    PH_READ:              step.step_kind <= STEP_RX_BYTE;
                    default:              step.step_kind <= STEP_TX_BYTE;
                endcase
            end else if (step.step_done) begin
                step.step_req <= 1'b0;
                case (phase)
                    PH_START:   phase <= PH_ADDR_W;
                    PH_ADDR_W:  phase <= rw_q ? PH_REG : PH_WRITE;
                    PH_WRITE, PH_READ: begin
                        if (trans_cnt == '0)
                            phase <= PH_STOP;
                        else
                            trans_cnt <= trans_cnt - 1'b1;
                    end
                    PH_REG: begin
                        if (dummy_cnt == '0)
                            phase <= PH_RESTART;
                        else
                            dummy_cnt <= dummy_cnt - 1'b1;
                    end
                    PH_RESTART: phase <= PH_ADDR_R;
                    PH_ADDR_R:  phase <= PH_READ;
                    PH_STOP: begin
                        if (again) begin
                            phase <= PH_START;
                            again <= 1'b0;
                        end else begin
                            phase    <= PH_IDLE;
                            cmd_done <= 1'b1;
                        end
                    end
                    default:    phase <= PH_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/i2c_bit_execute.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "i2c_cfg.svh"

module i2c_bit_execute (
    input  wire         clk,
    input  wire         rstn,
    input  wire         sda_in,
    output logic        scl_out,
    output logic        scl_enable,
    output logic        sda_out,
    output logic        sda_enable,
    i2c_step_if.execute step,
    i2c_done_if.execute done
);
    import i2c_pkg::*;

    localparam int QW = $clog2(`I2C_QUARTER_CLKS + 1);
    localparam logic [QW-1:0] Q_LAST = QW'(`I2C_QUARTER_CLKS - 1);

    logic          busy;
    logic [QW-1:0] qcnt;
    logic [1:0]    quarter;   // 0,1 scl low / 2,3 scl high
    logic [3:0]    bit_idx;   // 8 = ack slot
    logic [7:0]    tx_shift;
    logic [7:0]    rx_shift;
    logic          ack_q;
    logic          was_rx_q;
    logic          take_up;
    logic          is_byte;
    logic          q_first;
    logic          q_end;
    logic          bit_end;
    logic          step_end;

    assign take_up  = !busy && step.step_req && !step.step_done;
    assign is_byte  = (step.step_kind == STEP_TX_BYTE) || (step.step_kind == STEP_RX_BYTE);
    assign q_first  = busy && (qcnt == '0);
    assign q_end    = busy && (qcnt == Q_LAST);
    assign bit_end  = q_end && (quarter == 2'd3);
    assign step_end = bit_end && (!is_byte || (bit_idx == 4'd8)); // start/stop are one bit

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy           <= 1'b0;
            qcnt           <= '0;
            quarter        <= 2'd0;
            bit_idx        <= 4'd0;
            step.step_done <= 1'b0;
            done.byte_done <= 1'b0;
        end else begin
            step.step_done <= step_end;
            done.byte_done <= step_end && is_byte;
            if (take_up) begin
                busy    <= 1'b1;
                qcnt    <= '0;
                quarter <= 2'd0;
                bit_idx <= 4'd0;
            end else if (busy) begin
                if (q_end) begin
                    qcnt    <= '0;
                    quarter <= quarter + 1'b1;
                end else begin
                    qcnt <= qcnt + 1'b1;
                end
                if (bit_end)
                    bit_idx <= bit_idx + 1'b1;
                if (step_end)
                    busy <= 1'b0;
            end
        end
    end

    // outputs follow the quarter boundary by one clk
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            scl_out    <= 1'b1;
            scl_enable <= 1'b0;
            sda_out    <= 1'b1;
            sda_enable <= 1'b0;
        end else if (take_up && (step.step_kind == STEP_START)) begin
            scl_enable <= 1'b1;
        end else if (step_end && (step.step_kind == STEP_STOP)) begin
            scl_enable <= 1'b0; // both lines back to the pull-ups
            sda_enable <= 1'b0;
        end else if (q_first) begin
            case (quarter)
                2'd0: begin
                    scl_out <= 1'b0;
                    case (step.step_kind)
                        STEP_START: begin
                            sda_out    <= 1'b1;
                            sda_enable <= 1'b1;
                        end
                        STEP_STOP: begin
                            sda_out    <= 1'b0;
                            sda_enable <= 1'b1;
                        end
                        STEP_TX_BYTE: begin
                            sda_out    <= tx_shift[7];
                            sda_enable <= (bit_idx != 4'd8); // slave owns the ack slot
                        end
                        default: begin
                            sda_out    <= step.master_ack;
                            sda_enable <= (bit_idx == 4'd8);
                        end
                    endcase
                end
                2'd1: scl_out <= 1'b0;
                2'd2: scl_out <= 1'b1;
                default: begin
                    // sda edge with scl high makes the start or stop
                    if (!is_byte)
                        sda_out <= (step.step_kind == STEP_STOP);
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_up)
            tx_shift <= step.tx_byte;
        else if (bit_end)
            tx_shift <= {tx_shift[6:0], 1'b0};
        if (q_end && (quarter == 2'd2)) begin
            if (bit_idx == 4'd8)
                ack_q <= sda_in;
            else
                rx_shift <= {rx_shift[6:0], sda_in}; // msb first
        end
        if (step_end)
            was_rx_q <= (step.step_kind == STEP_RX_BYTE);
    end

    assign done.was_rx  = was_rx_q;
    assign done.rx_byte = rx_shift;
    assign done.ack_bit = ack_q;

endmodule

`default_nettype wire

// ==== verilog/i2c_byte_result.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "i2c_cfg.svh"

module i2c_byte_result (
    input  wire        clk,
    input  wire        rstn,
    i2c_done_if.result done,
    output logic       retry,
    output logic       abort,
    output logic       cmd_error,
    output logic [7:0] rd_data,
    output logic       rd_data_valid
);
    localparam int RW = $clog2(`I2C_MAX_RETRY + 1);
    localparam logic [RW-1:0] RETRY_LAST = RW'(`I2C_MAX_RETRY);

    logic [RW-1:0] retry_cnt;
    logic          tx_nack;
    logic          rx_last;

    assign tx_nack = done.byte_done && !done.was_rx && done.ack_bit;
    assign rx_last = done.byte_done && done.was_rx && done.ack_bit; // master nack ends the read

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            retry         <= 1'b0;
            abort         <= 1'b0;
            cmd_error     <= 1'b0;
            rd_data_valid <= 1'b0;
            retry_cnt     <= '0;
        end else begin
            retry         <= 1'b0;
            abort         <= 1'b0;
            rd_data_valid <= done.byte_done && done.was_rx;
            if (done.byte_done)
                cmd_error <= 1'b0; // next command is on the bus
            if (tx_nack) begin
                if (retry_cnt == RETRY_LAST) begin
                    abort     <= 1'b1;
                    cmd_error <= 1'b1;
                    retry_cnt <= '0;
                end else begin
                    retry     <= 1'b1;
                    retry_cnt <= retry_cnt + 1'b1;
                end
            end else if (rx_last) begin
                retry_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (done.byte_done && done.was_rx)
            rd_data <= done.rx_byte;
    end

endmodule

`default_nettype wire

// ==== verilog/i2c_master_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "i2c_cfg.svh"

module i2c_master_top (
    input  wire                  clk,
    input  wire                  rstn,
    input  wire                  cmd_valid,
    output wire                  cmd_ready,
    output wire                  cmd_done,
    output wire                  cmd_error,
    input  wire [6:0]            slave_addr,
    input  wire                  read_write,
    input  wire [`I2C_LEN_W-1:0] trans_length,
    input  wire [`I2C_LEN_W-1:0] dummy_length,
    output wire                  wr_data_ready,
    input  wire [7:0]            wr_data,
    output wire                  rd_data_valid,
    output wire [7:0]            rd_data,
    output wire                  scl_out,
    output wire                  scl_enable,
    input  wire                  sda_in,
    output wire                  sda_out,
    output wire                  sda_enable
);
    wire retry;
    wire abort;

    i2c_step_if step_bus ();
    i2c_done_if done_bus ();

    i2c_cmd_decode u_decode (
        .clk           (clk),
        .rstn          (rstn),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .cmd_done      (cmd_done),
        .slave_addr    (slave_addr),
        .read_write    (read_write),
        .trans_length  (trans_length),
        .dummy_length  (dummy_length),
        .wr_data_ready (wr_data_ready),
        .wr_data       (wr_data),
        .retry         (retry),
        .abort         (abort),
        .step          (step_bus.decode)
    );

    i2c_bit_execute u_execute (
        .clk        (clk),
        .rstn       (rstn),
        .sda_in     (sda_in),
        .scl_out    (scl_out),
        .scl_enable (scl_enable),
        .sda_out    (sda_out),
        .sda_enable (sda_enable),
        .step       (step_bus.execute),
        .done       (done_bus.execute)
    );

    i2c_byte_result u_result (
        .clk           (clk),
        .rstn          (rstn),
        .done          (done_bus.result),
        .retry         (retry),
        .abort         (abort),
        .cmd_error     (cmd_error),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid)
    );

endmodule

`default_nettype wire

// ==== test/i2c_slave_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_model #(
    parameter logic [6:0] ADDR = 7'h50
) (
    input  wire  scl,
    input  wire  sda,
    output logic sda_low
);
    localparam int M_IDLE = 0;
    localparam int M_ADDR = 1;
    localparam int M_PTR  = 2;
    localparam int M_WR   = 3;
    localparam int M_SEND = 4;

    logic [7:0] mem [256];
    logic [7:0] ptr;
    logic [7:0] shift_in;
    logic [7:0] tx_sh;
    logic       scl_prev;
    logic       sda_prev;
    logic       m_nack;   // master ack level after a sent byte
    int         mode;
    int         cnt;      // scl rising edges in the current byte
    int         start_count;

    initial begin
        for (int i = 0; i < 256; i++)
            mem[i] = 8'(i) ^ 8'ha5;
        sda_low     = 1'b0;
        ptr         = 8'h00;
        shift_in    = 8'h00;
        tx_sh       = 8'h00;
        scl_prev    = 1'b1;
        sda_prev    = 1'b1;
        m_nack      = 1'b1;
        mode        = M_IDLE;
        cnt         = 0;
        start_count = 0;
    end

    // lines settle for 1 ns, so an scl fall with a data change is just an scl fall
    always begin
        @(scl or sda);
        #1;
        if (scl_prev && scl && sda_prev && !sda) begin
            start_count++;
            mode    = M_ADDR;
            cnt     = 0;
            sda_low = 1'b0;
        end else if (scl_prev && scl && !sda_prev && sda) begin
            mode    = M_IDLE; // stop
            sda_low = 1'b0;
        end else if (!scl_prev && scl && mode != M_IDLE) begin
            if (cnt < 8)
                shift_in = {shift_in[6:0], sda};
            else if (mode == M_SEND)
                m_nack = sda;
            cnt++;
        end else if (scl_prev && !scl && mode != M_IDLE) begin
            if (cnt == 8) begin
                if (mode == M_SEND) begin
                    sda_low = 1'b0; // master owns the ack slot
                end else if (mode == M_ADDR) begin
                    if (shift_in[7:1] == ADDR) begin
                        sda_low = 1'b1;
                        mode    = shift_in[0] ? M_SEND : M_PTR;
                    end else begin
                        mode = M_IDLE; // other address gets a nack
                    end
                end else if (mode == M_PTR) begin
                    ptr     = shift_in;
                    mode    = M_WR;
                    sda_low = 1'b1;
                end else begin
                    mem[ptr] = shift_in;
                    ptr++;
                    sda_low  = 1'b1;
                end
            end else if (cnt == 9) begin
                cnt = 0;
                if (mode == M_SEND && !m_nack) begin
                    tx_sh   = mem[ptr];
                    ptr++;
                    sda_low = !tx_sh[7];
                end else begin
                    sda_low = 1'b0;
                    if (mode == M_SEND)
                        mode = M_IDLE;
                end
            end else if (mode == M_SEND) begin
                sda_low = !tx_sh[3'(7 - cnt)];
            end
        end
        scl_prev = scl;
        sda_prev = sda;
    end

endmodule

`default_nettype wire

// ==== test/tb_i2c_master.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "i2c_cfg.svh"

module tb_i2c_master;
    localparam int TIMEOUT = 5000 * `I2C_QUARTER_CLKS; // clk cycles per wait

    logic                  clk = 1'b0;
    logic                  rstn;
    logic                  cmd_valid;
    logic [6:0]            slave_addr;
    logic                  read_write;
    logic [`I2C_LEN_W-1:0] trans_length;
    logic [`I2C_LEN_W-1:0] dummy_length;
    logic [7:0]            wr_data = 8'h00;
    wire                   cmd_ready;
    wire                   cmd_done;
    wire                   cmd_error;
    wire                   wr_data_ready;
    wire                   rd_data_valid;
    wire  [7:0]            rd_data;
    wire                   scl_out;
    wire                   scl_enable;
    wire                   sda_out;
    wire                   sda_enable;
    wire                   slave_low;
    wire                   scl_line;
    wire                   sda_line;

    logic [7:0]  shadow [256];
    logic [7:0]  wr_bytes [64];
    logic [5:0]  wr_idx = 6'd0;     // wr_data_ready pulses so far
    logic        wr_seen = 1'b0;
    logic [7:0]  rd_idx = 8'd0;     // rd_data_valid pulses so far
    logic [7:0]  rd_base = 8'd0;
    logic [7:0]  rd_start = 8'd0;
    logic [7:0]  exp_byte;
    logic [15:0] lfsr_state = 16'd88;
    logic        timed_out = 1'b0;
    int          errors = 0;
    int          checks = 0;

    // open drain with pull-ups
    assign scl_line = !(scl_enable && !scl_out);
    assign sda_line = !(sda_enable && !sda_out) && !slave_low;

    i2c_master_top dut0 (
        .clk           (clk),
        .rstn          (rstn),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .cmd_done      (cmd_done),
        .cmd_error     (cmd_error),
        .slave_addr    (slave_addr),
        .read_write    (read_write),
        .trans_length  (trans_length),
        .dummy_length  (dummy_length),
        .wr_data_ready (wr_data_ready),
        .wr_data       (wr_data),
        .rd_data_valid (rd_data_valid),
        .rd_data       (rd_data),
        .scl_out       (scl_out),
        .scl_enable    (scl_enable),
        .sda_in        (sda_line),
        .sda_out       (sda_out),
        .sda_enable    (sda_enable)
    );

    i2c_slave_model slv0 (.scl(scl_line), .sda(sda_line), .sda_low(slave_low));

    always #4 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [7:0] v);
        v = 8'h00;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
    endtask

    // expected slave memory updated by each write
    function automatic logic [7:0] ref_model(input logic wr, input logic [7:0] addr,
                                             input logic [7:0] data);
        if (wr)
            shadow[addr] = data;
        return shadow[addr];
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // next write byte appears one negedge after each pulse
    always @(negedge clk) begin
        if (wr_seen)
            wr_idx = wr_idx + 6'd1;
        wr_seen = wr_data_ready;
        wr_data = wr_bytes[wr_idx];
    end

    always @(negedge clk) begin
        if (rd_data_valid) begin
            exp_byte = ref_model(1'b0, rd_base + rd_idx - rd_start, 8'h00);
            checks++;
            if (rd_data !== exp_byte) begin
                $display("CHECK FAILED rd_data: got %h expected %h", rd_data, exp_byte);
                errors++;
            end
            rd_idx = rd_idx + 8'd1;
        end
    end

    task automatic send_cmd(input logic [6:0] addr, input logic rw, input logic [7:0] tlen,
                            input logic [7:0] dlen, output logic err);
        int n;
        err = 1'b0;
        n = 0;
        while (!cmd_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!cmd_ready) begin
            $display("timed out waiting for cmd_ready");
            errors++;
            timed_out = 1'b1;
            return;
        end
        slave_addr   = addr;
        read_write   = rw;
        trans_length = tlen;
        dummy_length = dlen;
        cmd_valid    = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
        n = 0;
        while (!cmd_done && n < TIMEOUT) begin
            check_val("cmd_ready", 32'(cmd_ready), 32'(0));
            @(negedge clk);
            n++;
        end
        if (!cmd_done) begin
            $display("timed out waiting for cmd_done");
            errors++;
            timed_out = 1'b1;
            return;
        end
        err = cmd_error;
    endtask

    task automatic write_burst(input logic [7:0] ptr, input logic [7:0] n_data);
        logic [5:0] base;
        logic [7:0] d;
        logic       err;
        base = wr_idx;
        wr_bytes[base] = ptr;
        for (int i = 0; i < int'(n_data); i++) begin
            rand_bits(8, d);
            wr_bytes[6'(base + 6'(i + 1))] = d;
            d = ref_model(1'b1, ptr + 8'(i), d);
        end
        send_cmd(7'h50, 1'b0, n_data, 8'h00, err);
        if (timed_out)
            return;
        check_val("cmd_error", 32'(err), 32'(0));
        check_val("wr_data_ready pulses", 32'(6'(wr_idx - base)), 32'(n_data) + 1);
        for (int i = 0; i < int'(n_data); i++)
            check_val("slave mem", 32'(slv0.mem[ptr + 8'(i)]),
                      32'(ref_model(1'b0, ptr + 8'(i), 8'h00)));
    endtask

    task automatic read_burst(input logic [7:0] ptr, input logic [7:0] tlen);
        logic [5:0] base;
        logic       err;
        base = wr_idx;
        wr_bytes[base] = ptr;
        rd_base  = ptr;
        rd_start = rd_idx;
        send_cmd(7'h50, 1'b1, tlen, 8'h00, err);
        if (timed_out)
            return;
        check_val("cmd_error", 32'(err), 32'(0));
        check_val("wr_data_ready pulses", 32'(6'(wr_idx - base)), 32'(1));
        check_val("rd_data_valid pulses", 32'(8'(rd_idx - rd_start)), 32'(tlen) + 1);
    endtask

    task automatic test_sequence();
        logic [7:0] ptr;
        logic [7:0] v;
        logic [5:0] base;
        logic       err;
        int         starts;
        check_val("cmd_ready", 32'(cmd_ready), 32'(1));
        check_val("scl_enable", 32'(scl_enable), 32'(0));
        check_val("sda_enable", 32'(sda_enable), 32'(0));
        check_val("cmd_done", 32'(cmd_done), 32'(0));
        check_val("cmd_error", 32'(cmd_error), 32'(0));

        rand_bits(8, ptr);
        write_burst(ptr, 8'd4);
        if (timed_out)
            return;
        read_burst(ptr, 8'd5);
        if (timed_out)
            return;

        // nobody answers 7'h33
        starts = slv0.start_count;
        base   = wr_idx;
        send_cmd(7'h33, 1'b0, 8'd2, 8'h00, err);
        if (timed_out)
            return;
        check_val("start events", 32'(slv0.start_count - starts), 32'(`I2C_MAX_RETRY + 1));
        check_val("cmd_error", 32'(err), 32'(1));
        check_val("wr_data_ready pulses", 32'(6'(wr_idx - base)), 32'(0));

        rand_bits(8, ptr);
        rand_bits(3, v);
        write_burst(ptr, v + 8'd1);
        if (timed_out)
            return;
        rand_bits(3, v);
        read_burst(ptr, v);
    endtask

    task automatic report_result();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    endtask

    initial begin
        for (int i = 0; i < 256; i++)
            shadow[i] = 8'(i) ^ 8'ha5; // same fill as the slave
        for (int i = 0; i < 64; i++)
            wr_bytes[i] = 8'h00;
        rstn         = 1'b0;
        cmd_valid    = 1'b0;
        slave_addr   = 7'h00;
        read_write   = 1'b0;
        trans_length = '0;
        dummy_length = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        test_sequence();
        report_result();
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verilog
verilog/i2c_pkg.sv
verilog/i2c_if.sv
verilog/i2c_cmd_decode.sv
verilog/i2c_bit_execute.sv
verilog/i2c_byte_result.sv
verilog/i2c_master_top.sv
test/i2c_slave_model.sv
test/tb_i2c_master.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_i2c_master \
    --Mdir obj_dir -o tb_i2c_master
./obj_dir/tb_i2c_master > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
grep -q "SIMULATION PASSED" sim.log
